// ==== filelist.f ====
common/lwe_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/word_loader.sv
source/lwe_bank.sv
source/result_dump.sv
encrypt/enc_sequencer.sv
encrypt/mac_lane.sv
encrypt/b_writeback.sv
source/lwe_top.sv
tests/tb_lwe.sv

// ==== Makefile ====
TOP := tb_lwe

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_lwe.sv ====
module tb_lwe import lwe_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   logic clk_100mhz;
   logic sys_rst;
   logic uart_rxd;
   logic start;
   logic uart_txd;
   logic enc_done;

   // model of the loaded banks where b tracks the expected bank state
   word_t      a_words  [A_WORDS];
   word_t      pt_words [PT_WORDS];
   word_t      sk_words [SK_WORDS];
   b_word_t    b_model  [B_WORDS];
   word_t      rng_state = 32'd5;
   int         err_count = 0;

   logic [7:0] rx_bytes  [$];   // decoded from uart_txd
   b_word_t    exp_words [$];   // words still to come out of the dump
   logic       mon_active = 1'b0;
   int         mon_cnt    = 0;
   int         mon_bit    = 0;
   logic [7:0] mon_shift  = '0;
   int         done_count = 0;
   b_word_t    got_word;
   string      word_name;

   lwe_top UUT (.clk_100mhz, .sys_rst, .uart_rxd, .start, .uart_txd, .enc_done);

   initial begin
      clk_100mhz = 1'b0;
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   function automatic word_t next_rand();
      word_t x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   // new b word for row pair k by the LWE rule
   function automatic b_word_t ref_b_word(input int k);
      b_word_t r;
      coef_t   acc;
      coef_t   a_c;
      coef_t   s_c;
      for (int l = 0; l < LANES; l++) begin
         acc = b_model[k][l];
         for (int j = 0; j < LWE_N; j++) begin
            a_c = a_words[k * LWE_N + j][16 * l +: 16];   // row 2k+l, column j
            s_c = {{14{sk_words[j][1]}}, sk_words[j][1:0]};
            acc = acc + a_c * s_c;   // wraps mod 2^16
         end
         if (pt_words[k][l]) acc = acc + (coef_t'(1) << ERR_SHIFT);
         r[l] = acc;
      end
      return r;
   endfunction

   task automatic abort_run();
      $display("Test failures found");
      err_count++;
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic stop_with_reason(input string why);
      $display("%s", why);
      abort_run();
   endtask

   task automatic check_word(input string name, input b_word_t got, input b_word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic expect_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   // uart_txd decoder sampling mid bit
   always @(posedge clk_100mhz) begin
      if (enc_done) done_count <= done_count + 1;
      if (sys_rst) begin
         mon_active <= 1'b0;
      end else if (!mon_active) begin
         if (!uart_txd) begin
            mon_active <= 1'b1;
            mon_cnt    <= BAUD_DIV / 2 - 1;
            mon_bit    <= 0;
         end
      end else if (mon_cnt != 0) begin
         mon_cnt <= mon_cnt - 1;
      end else begin
         mon_cnt <= BAUD_DIV - 1;
         mon_bit <= mon_bit + 1;
         if (mon_bit == 0 && uart_txd) begin
            stop_with_reason("start bit on uart_txd ended before mid bit");
         end else if (mon_bit >= 1 && mon_bit <= 8) begin
            mon_shift <= {uart_txd, mon_shift[7:1]};   // lsb first
         end else if (mon_bit == 9) begin
            if (!uart_txd) begin
               stop_with_reason("stop bit missing on uart_txd");
            end else begin
               rx_bytes.push_back(mon_shift);
               mon_active <= 1'b0;
            end
         end
      end
   end

   // every four bytes form one b word in little-endian order
   always @(posedge clk_100mhz) begin
      if (rx_bytes.size() >= 4) begin
         got_word = {rx_bytes[3], rx_bytes[2], rx_bytes[1], rx_bytes[0]};
         repeat (4) rx_bytes.delete(0);
         if (exp_words.size() == 0) begin
            stop_with_reason("uart_txd sent a word that was not expected");
         end else begin
            word_name = $sformatf("b_word[%0d]", B_WORDS - exp_words.size());
            check_word(word_name, got_word, exp_words.pop_front());
         end
      end
   end

   task automatic apply_reset();
      @(posedge clk_100mhz);
      sys_rst  <= 1'b1;
      start    <= 1'b0;
      uart_rxd <= 1'b1;
      repeat (2) @(posedge clk_100mhz);
      sys_rst <= 1'b0;
   endtask

   task automatic send_byte(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};   // stop, data, start
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_100mhz);
         uart_rxd <= frame[i];
         repeat (BAUD_DIV - 1) @(posedge clk_100mhz);
      end
   endtask

   task automatic send_word(input word_t w);
      for (int i = 0; i < 4; i++) send_byte(w[8 * i +: 8]);
   endtask

   // same order as the loader's word counter regions
   task automatic load_banks();
      for (int i = 0; i < A_WORDS; i++) send_word(a_words[i]);
      for (int i = 0; i < PT_WORDS; i++) send_word(pt_words[i]);
      for (int i = 0; i < SK_WORDS; i++) send_word(sk_words[i]);
      for (int i = 0; i < B_WORDS; i++) send_word(word_t'(b_model[i]));
   endtask

   task automatic fill_random();
      for (int i = 0; i < A_WORDS; i++) a_words[i] = next_rand();
      for (int i = 0; i < PT_WORDS; i++) pt_words[i] = next_rand();
      for (int i = 0; i < SK_WORDS; i++) sk_words[i] = next_rand();   // only low 2 bits used
      for (int i = 0; i < B_WORDS; i++) b_model[i] = b_word_t'(next_rand());
   endtask

   task automatic queue_reference();
      for (int k = 0; k < B_WORDS; k++) begin
         b_model[k] = ref_b_word(k);
         exp_words.push_back(b_model[k]);
      end
   endtask

   task automatic idle_check(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk_100mhz);
         check_bit("uart_txd", uart_txd, 1'b1);
         check_bit("enc_done", enc_done, 1'b0);
      end
   endtask

   task automatic wait_enc_done(input int limit);
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk_100mhz);
         cycles++;
      end while (!enc_done && cycles < limit);
      if (!enc_done) stop_with_reason("timeout waiting for enc_done");
   endtask

   task automatic wait_dump(input int limit);
      int cycles;
      cycles = 0;
      while (exp_words.size() != 0 && cycles < limit) begin
         @(posedge clk_100mhz);
         cycles++;
      end
      if (exp_words.size() != 0) stop_with_reason("timeout waiting for the b dump on uart_txd");
   endtask

   // one start edge and one done pulse, then the full dump and silence
   task automatic run_pass(input int passes);
      @(posedge clk_100mhz);
      start <= 1'b1;
      repeat (2) @(posedge clk_100mhz);
      start <= 1'b0;
      wait_enc_done(10 * (ROW_PAIRS * LWE_N + 4));
      @(posedge clk_100mhz);
      check_bit("enc_done", enc_done, 1'b0);   // single cycle pulse
      wait_dump(B_WORDS * 4 * 12 * BAUD_DIV);
      idle_check(3 * 10 * BAUD_DIV);
      expect_count("extra tx bytes", rx_bytes.size(), 0);
      expect_count("enc_done pulses", done_count, passes);
   endtask

   initial begin
      sys_rst  = 1'b1;
      start    = 1'b0;
      uart_rxd = 1'b1;
      apply_reset();

      idle_check(2000);   // nothing moves without start

      fill_random();
      load_banks();
      queue_reference();
      run_pass(1);

      queue_reference();   // b accumulates so the reference applies twice
      run_pass(2);

      // zero A with every pt bit set leaves only the error term
      apply_reset();
      fill_random();
      for (int i = 0; i < A_WORDS; i++) a_words[i] = '0;
      for (int i = 0; i < PT_WORDS; i++) pt_words[i] = pt_words[i] | 32'h3;
      load_banks();
      for (int k = 0; k < B_WORDS; k++) begin
         for (int l = 0; l < LANES; l++) b_model[k][l] = b_model[k][l] + 16'd1024;
         exp_words.push_back(b_model[k]);
      end
      run_pass(3);

      apply_reset();   // fresh data over everything
      fill_random();
      load_banks();
      queue_reference();
      run_pass(4);

      if (err_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== source/lwe_top.sv ====
module lwe_top import lwe_pkg::*; (
   input  logic clk_100mhz,
   input  logic sys_rst,
   input  logic uart_rxd,
   input  logic start,
   output logic uart_txd,
   output logic enc_done
);
   logic       rx_valid;
   logic [7:0] rx_byte;
   bank_wr_t   wr_a, wr_pt, wr_sk, wr_b_load, wr_b;

   addr_t      a_rd_addr  [1];
   addr_t      pt_rd_addr [1];
   addr_t      sk_rd_addr [1];
   addr_t      b_rd_addr  [2];    // 0 writeback, 1 dump
   a_word_t    a_rd       [1];
   pt_word_t   pt_rd      [1];
   sk_t        sk_rd      [1];
   b_word_t    b_rd       [2];

   row_tag_t   tag;
   logic       running;
   lane_out_t  lane_out [LANES];
   logic       dump_busy;
   logic       tx_trigger, tx_busy;
   logic [7:0] tx_byte;

   uart_rx u_rx (.clk_100mhz, .sys_rst, .rxd(uart_rxd),
                 .byte_valid(rx_valid), .byte_data(rx_byte));

   word_loader u_loader (.clk_100mhz, .sys_rst, .byte_valid(rx_valid), .byte_data(rx_byte),
                         .wr_a, .wr_pt, .wr_sk, .wr_b(wr_b_load));

   lwe_bank #(.payload_t(a_word_t), .DEPTH(A_WORDS), .NUM_RD(1)) u_a_bank (
      .clk_100mhz, .wr(wr_a), .rd_addr(a_rd_addr), .rd_data(a_rd));
   lwe_bank #(.payload_t(pt_word_t), .DEPTH(PT_WORDS), .NUM_RD(1)) u_pt_bank (
      .clk_100mhz, .wr(wr_pt), .rd_addr(pt_rd_addr), .rd_data(pt_rd));
   lwe_bank #(.payload_t(sk_t), .DEPTH(SK_WORDS), .NUM_RD(1)) u_sk_bank (
      .clk_100mhz, .wr(wr_sk), .rd_addr(sk_rd_addr), .rd_data(sk_rd));
   lwe_bank #(.payload_t(b_word_t), .DEPTH(B_WORDS), .NUM_RD(2)) u_b_bank (
      .clk_100mhz, .wr(wr_b), .rd_addr(b_rd_addr), .rd_data(b_rd));

   enc_sequencer u_seq (.clk_100mhz, .sys_rst, .start, .dump_busy,
                        .a_addr(a_rd_addr[0]), .sk_addr(sk_rd_addr[0]), .tag, .running);

   // each lane takes its half of the A word, s is shared
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      lane_in_t beat;
      assign beat = '{valid: tag.valid, last: tag.last, a: a_rd[0][l], s: sk_rd[0]};
      mac_lane u_lane (.clk_100mhz, .sys_rst, .beat, .result(lane_out[l]));
   end

   b_writeback u_wb (.clk_100mhz, .sys_rst, .running, .sums(lane_out), .tag,
                     .load_wr(wr_b_load), .b_rd_addr(b_rd_addr[0]),
                     .pt_rd_addr(pt_rd_addr[0]), .b_rd(b_rd[0]), .pt_rd(pt_rd[0]),
                     .b_wr(wr_b), .done(enc_done));

   result_dump u_dump (.clk_100mhz, .sys_rst, .done(enc_done),
                       .b_rd_addr(b_rd_addr[1]), .b_rd(b_rd[1]), .tx_busy,
                       .tx_trigger, .tx_byte, .busy(dump_busy));

   uart_tx u_tx (.clk_100mhz, .sys_rst, .trigger(tx_trigger), .byte_data(tx_byte),
                 .busy(tx_busy), .txd(uart_txd));

endmodule

// ==== encrypt/b_writeback.sv ====
module b_writeback import lwe_pkg::*; (
   input  logic      clk_100mhz,
   input  logic      sys_rst,
   input  logic      running,
   input  lane_out_t sums [LANES],
   input  row_tag_t  tag,
   input  bank_wr_t  load_wr,
   output addr_t     b_rd_addr,
   output addr_t     pt_rd_addr,
   input  b_word_t   b_rd,
   input  pt_word_t  pt_rd,
   output bank_wr_t  b_wr,
   output logic      done
);
   rp_t     rp_q;                  // row pair of the beat marked last
   rp_t     s1_rp, s2_rp;
   b_word_t s1_sum, s2_sum;
   logic    s1_valid, s2_valid;
   logic    sums_valid;
   logic    last_write;
   logic    active;                // pass still draining after running drops
   b_word_t new_b;

   always_comb begin
      sums_valid = 1'b1;
      for (int l = 0; l < LANES; l++) sums_valid &= sums[l].valid;
   end

   assign last_write = s2_valid && s2_rp == rp_t'(ROW_PAIRS - 1);
   assign b_rd_addr  = addr_t'(s1_rp);    // old b and pt come back in stage 2
   assign pt_rd_addr = addr_t'(s1_rp);

   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         new_b[l] = b_rd[l] + s2_sum[l] + (coef_t'(pt_rd[l]) << ERR_SHIFT);
      end
      if (s2_valid) b_wr = '{en: 1'b1, addr: addr_t'(s2_rp), data: word_t'(new_b)};
      else if (running || active) b_wr = '0;   // loader locked out mid pass
      else b_wr = load_wr;
   end

   always_ff @(posedge clk_100mhz) begin
      if (tag.valid && tag.last) rp_q <= tag.row_pair;
      if (sums_valid) begin
         s1_rp <= rp_q;
         for (int l = 0; l < LANES; l++) s1_sum[l] <= sums[l].sum;
      end
      s2_rp  <= s1_rp;
      s2_sum <= s1_sum;
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         active   <= 1'b0;
         done     <= 1'b0;
      end else begin
         s1_valid <= sums_valid;
         s2_valid <= s1_valid;
         done     <= last_write;   // one cycle after the final b write
         if (running) active <= 1'b1;
         else if (last_write) active <= 1'b0;
      end
   end

endmodule

// ==== encrypt/mac_lane.sv ====
module mac_lane import lwe_pkg::*; (
   input  logic      clk_100mhz,
   input  logic      sys_rst,
   input  lane_in_t  beat,
   output lane_out_t result
);
   coef_t acc;
   coef_t s_ext;
   coef_t prod;
   coef_t acc_next;

   always_comb begin
      s_ext    = coef_t'(beat.s);           // sk_t is signed so this sign-extends
      prod     = coef_t'(beat.a * s_ext);   // low 16 bits, wraps mod 2^16
      acc_next = acc + prod;
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         acc          <= '0;
         result.valid <= 1'b0;
      end else begin
         result.valid <= beat.valid && beat.last;
         if (beat.valid) begin
            if (beat.last) begin
               result.sum <= acc_next;
               acc        <= '0;   // next row pair starts clean
            end else begin
               acc <= acc_next;
            end
         end
      end
   end

endmodule

// ==== encrypt/enc_sequencer.sv ====
module enc_sequencer import lwe_pkg::*; (
   input  logic     clk_100mhz,
   input  logic     sys_rst,
   input  logic     start,
   input  logic     dump_busy,
   output addr_t    a_addr,
   output addr_t    sk_addr,
   output row_tag_t tag,
   output logic     running
);
   typedef logic [$clog2(LWE_N)-1:0] col_t;

   logic start_q;    // for edge detect
   rp_t  rp;
   col_t col;
   logic col_last;

   assign col_last = (col == col_t'(LWE_N - 1));

   // A is stored row pair major, one column per word
   assign a_addr  = addr_t'(int'(rp) * LWE_N + int'(col));
   assign sk_addr = addr_t'(col);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         start_q <= 1'b0;
         running <= 1'b0;
         rp      <= '0;
         col     <= '0;
         tag     <= '0;
      end else begin
         start_q <= start;

         // tag lags the addresses by one, lines up with bank data
         tag.valid    <= running;
         tag.last     <= running && col_last;
         tag.row_pair <= rp;

         if (!running) begin
            if (start && !start_q && !dump_busy) begin   // rising start only
               running <= 1'b1;
               rp      <= '0;
               col     <= '0;
            end
         end else if (col_last) begin
            col <= '0;
            if (rp == rp_t'(ROW_PAIRS - 1)) running <= 1'b0;   // last beat issued
            else rp <= rp + 1'b1;
         end else begin
            col <= col + 1'b1;
         end
      end
   end

endmodule

// ==== source/result_dump.sv ====
module result_dump import lwe_pkg::*; (
   input  logic       clk_100mhz,
   input  logic       sys_rst,
   input  logic       done,
   output addr_t      b_rd_addr,
   input  b_word_t    b_rd,
   input  logic       tx_busy,
   output logic       tx_trigger,
   output logic [7:0] tx_byte,
   output logic       busy
);
   typedef enum logic [1:0] {D_IDLE, D_FETCH, D_SEND, D_DRAIN} dump_state_t;
   typedef logic [$clog2(B_WORDS)-1:0] widx_t;

   dump_state_t state;
   widx_t       word_idx;
   logic [1:0]  byte_idx;
   word_t       b_flat;

   assign b_rd_addr  = addr_t'(word_idx);
   assign b_flat     = b_rd;                        // lane 0 coef in low half
   assign tx_byte    = b_flat[8*byte_idx +: 8];     // low byte first
   assign tx_trigger = (state == D_SEND) && !tx_busy;
   assign busy       = (state != D_IDLE);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         state    <= D_IDLE;
         word_idx <= '0;
         byte_idx <= '0;
      end else begin
         case (state)
            D_IDLE: if (done) begin
               word_idx <= '0;
               byte_idx <= '0;
               state    <= D_FETCH;
            end
            D_FETCH: state <= D_SEND;               // one cycle read latency
            D_SEND:  if (!tx_busy) state <= D_DRAIN; // tx sees trigger this edge
            D_DRAIN: if (!tx_busy) begin
               byte_idx <= byte_idx + 1'b1;
               if (byte_idx != 2'd3) begin
                  state <= D_SEND;
               end else if (word_idx == widx_t'(B_WORDS - 1)) begin
                  state <= D_IDLE;
               end else begin
                  word_idx <= word_idx + 1'b1;
                  state    <= D_FETCH;
               end
            end
            default: state <= D_IDLE;
         endcase
      end
   end

endmodule

// ==== source/lwe_bank.sv ====
module lwe_bank import lwe_pkg::*; #(
   parameter type payload_t = word_t,
   parameter int  DEPTH     = 4,
   parameter int  NUM_RD    = 1
) (
   input  logic     clk_100mhz,
   input  bank_wr_t wr,
   input  addr_t    rd_addr [NUM_RD],
   output payload_t rd_data [NUM_RD]
);
   payload_t mem [DEPTH];

   initial begin
      for (int i = 0; i < DEPTH; i++) mem[i] = '0;   // banks power up cleared
   end

   always_ff @(posedge clk_100mhz) begin
      // only the low bits of the loaded word carry this bank's payload
      if (wr.en) mem[wr.addr[$clog2(DEPTH)-1:0]] <= wr.data[$bits(payload_t)-1:0];
      for (int p = 0; p < NUM_RD; p++) begin
         rd_data[p] <= mem[rd_addr[p][$clog2(DEPTH)-1:0]];   // read-first
      end
   end

endmodule

// ==== source/word_loader.sv ====
module word_loader import lwe_pkg::*; (
   input  logic       clk_100mhz,
   input  logic       sys_rst,
   input  logic       byte_valid,
   input  logic [7:0] byte_data,
   output bank_wr_t   wr_a,
   output bank_wr_t   wr_pt,
   output bank_wr_t   wr_sk,
   output bank_wr_t   wr_b
);
   logic [1:0]                          byte_cnt;
   logic [23:0]                         low_bytes;   // first three bytes of the word
   logic [$clog2(LOAD_WORDS+1)-1:0]     word_cnt;    // saturates at LOAD_WORDS
   int                                  cnt;
   logic                                take;
   word_t                               word;

   assign cnt  = int'(word_cnt);
   assign word = {byte_data, low_bytes};   // 4th byte is the top one
   assign take = byte_valid && byte_cnt == 2'd3 && cnt < LOAD_WORDS;

   always_ff @(posedge clk_100mhz) begin
      if (byte_valid) low_bytes <= {byte_data, low_bytes[23:8]};

      if (sys_rst) begin
         byte_cnt <= '0;
         word_cnt <= '0;
         wr_a     <= '0;
         wr_pt    <= '0;
         wr_sk    <= '0;
         wr_b     <= '0;
      end else begin
         if (byte_valid) byte_cnt <= byte_cnt + 1'b1;
         if (take) word_cnt <= word_cnt + 1'b1;

         // region decode, addr relative to each bank base
         wr_a  <= '{en: take && cnt < PT_BASE,
                    addr: addr_t'(cnt - A_BASE), data: word};
         wr_pt <= '{en: take && cnt >= PT_BASE && cnt < SK_BASE,
                    addr: addr_t'(cnt - PT_BASE), data: word};
         wr_sk <= '{en: take && cnt >= SK_BASE && cnt < B_BASE,
                    addr: addr_t'(cnt - SK_BASE), data: word};
         wr_b  <= '{en: take && cnt >= B_BASE,
                    addr: addr_t'(cnt - B_BASE), data: word};
      end
   end

endmodule

// ==== source/uart_tx.sv ====
module uart_tx import lwe_pkg::*; (
   input  logic       clk_100mhz,
   input  logic       sys_rst,
   input  logic       trigger,
   input  logic [7:0] byte_data,
   output logic       busy,
   output logic       txd
);
   logic [8:0] shreg;       // data bits then stop bit
   logic [3:0] bits_left;   // bits still to go after the current one
   baud_t      baud_cnt;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         busy      <= 1'b0;
         txd       <= 1'b1;   // idle high
         bits_left <= '0;
         baud_cnt  <= '0;
      end else if (!busy) begin
         if (trigger) begin
            busy      <= 1'b1;
            txd       <= 1'b0;              // start bit
            shreg     <= {1'b1, byte_data};
            bits_left <= 4'd9;
            baud_cnt  <= baud_t'(BAUD_DIV - 1);
         end
      end else if (baud_cnt != '0) begin
         baud_cnt <= baud_cnt - 1'b1;
      end else if (bits_left == '0) begin
         busy <= 1'b0;        // stop bit done, txd already high
      end else begin
         txd       <= shreg[0];
         shreg     <= {1'b1, shreg[8:1]};
         bits_left <= bits_left - 1'b1;
         baud_cnt  <= baud_t'(BAUD_DIV - 1);
      end
   end

endmodule

// ==== source/uart_rx.sv ====
module uart_rx import lwe_pkg::*; (
   input  logic       clk_100mhz,
   input  logic       sys_rst,
   input  logic       rxd,
   output logic       byte_valid,
   output logic [7:0] byte_data
);
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t  state;
   logic       rx_meta, rx_sync;   // two-flop synchronizer
   baud_t      baud_cnt;           // counts down to the next sample point
   logic [2:0] bit_idx;
   logic [7:0] shreg;

   assign byte_data = shreg;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         rx_meta    <= 1'b1;       // line idles high
         rx_sync    <= 1'b1;
         state      <= RX_IDLE;
         baud_cnt   <= '0;
         bit_idx    <= '0;
         byte_valid <= 1'b0;
      end else begin
         rx_meta    <= rxd;
         rx_sync    <= rx_meta;
         byte_valid <= 1'b0;
         case (state)
            RX_IDLE: if (!rx_sync) begin
               state    <= RX_START;
               baud_cnt <= baud_t'(BAUD_DIV / 2 - 1);   // aim for mid start bit
            end
            RX_START: if (baud_cnt == '0) begin
               // glitch shorter than half a bit goes back to idle
               state    <= rx_sync ? RX_IDLE : RX_DATA;
               baud_cnt <= baud_t'(BAUD_DIV - 1);
               bit_idx  <= '0;
            end else begin
               baud_cnt <= baud_cnt - 1'b1;
            end
            RX_DATA: if (baud_cnt == '0) begin
               shreg    <= {rx_sync, shreg[7:1]};   // lsb first
               bit_idx  <= bit_idx + 1'b1;
               baud_cnt <= baud_t'(BAUD_DIV - 1);
               if (bit_idx == 3'd7) state <= RX_STOP;
            end else begin
               baud_cnt <= baud_cnt - 1'b1;
            end
            RX_STOP: if (baud_cnt == '0) begin
               byte_valid <= rx_sync;   // framing error drops the byte
               state      <= RX_IDLE;
            end else begin
               baud_cnt <= baud_cnt - 1'b1;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

// ==== common/lwe_pkg.sv ====
package lwe_pkg;

   // problem size
   localparam int LWE_N     = 8;                   // secret length
   localparam int LWE_M     = 8;                   // output rows
   localparam int LANES     = 2;
   localparam int ROW_PAIRS = LWE_M / LANES;

   // bank depths in words
   localparam int A_WORDS  = ROW_PAIRS * LWE_N;    // two coefs per word
   localparam int PT_WORDS = ROW_PAIRS;
   localparam int SK_WORDS = LWE_N;
   localparam int B_WORDS  = ROW_PAIRS;

   // word counter regions while loading, A first
   localparam int A_BASE     = 0;
   localparam int PT_BASE    = A_BASE + A_WORDS;
   localparam int SK_BASE    = PT_BASE + PT_WORDS;
   localparam int B_BASE     = SK_BASE + SK_WORDS;
   localparam int LOAD_WORDS = B_BASE + B_WORDS;

   localparam int ERR_SHIFT = 10;                  // pt bit scaled to q/64
   localparam int BAUD_DIV  = 868;                 // 100 MHz / 115200

   typedef logic [15:0]                   coef_t;
   typedef logic signed [1:0]             sk_t;   // -2..1, sign-extended on use
   typedef logic [31:0]                   word_t;
   typedef logic [5:0]                    addr_t;
   typedef logic [$clog2(ROW_PAIRS)-1:0]  rp_t;
   typedef logic [$clog2(BAUD_DIV)-1:0]   baud_t;

   typedef coef_t [LANES-1:0] a_word_t;           // [0] = lane 0, low half
   typedef logic  [LANES-1:0] pt_word_t;          // bit l for lane l
   typedef coef_t [LANES-1:0] b_word_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
   } bank_wr_t;

   typedef struct packed {
      logic  valid;
      logic  last;      // final column of the row
      coef_t a;
      sk_t   s;
   } lane_in_t;

   typedef struct packed {
      logic  valid;
      coef_t sum;
   } lane_out_t;

   typedef struct packed {
      logic valid;
      logic last;
      rp_t  row_pair;
   } row_tag_t;

endpackage
